/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // 2-bit saturating counter, msb is the predicted direction
    typedef enum logic [1:0] {
        strong_not   = 2'b00,
        weak_not     = 2'b01,  // reset state
        weak_taken   = 2'b10,
        strong_taken = 2'b11
    } counter_e;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,  // beq/bne/blt/bge/bltu/bgeu
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_alu    = 7'b0110011,
        op_alui   = 7'b0010011
    } opcode_e;

    // table geometry
    localparam int N_BANKS    = 4;
    localparam int BANK_W     = 2;   // pc[3:2]
    localparam int BANK_DEPTH = 64;
    localparam int INDEX_W    = 6;   // pc[9:4]

    typedef struct packed {
        logic [BANK_W-1:0]  bank;
        logic [INDEX_W-1:0] index;
    } table_addr_t;

    // fetch side lookup
    typedef struct packed {
        logic        valid;
        table_addr_t addr;
        logic [31:0] pc;    // zero when not a branch
    } lookup_req_t;

    // resolved branch from mem stage
    typedef struct packed {
        logic        valid;
        table_addr_t addr;
        logic        taken;
    } update_req_t;

    // per-bank registered outputs
    typedef struct packed {
        counter_e read_state;  // lookup result
        counter_e old_state;   // counter before the last write
    } bank_resp_t;

endpackage

`default_nettype wire

/* branch_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_detect (
    input  wire  logic [6:0]          opcode,         // fetched instruction opcode
    input  wire  logic [31:0]         pc,             // fetch pc
    input  wire  logic                resolve_valid,  // mem stage strobe
    input  wire  logic [31:0]         resolve_pc,
    input  wire  logic                resolve_taken,
    output logic                      is_branch,
    output bp_pkg::lookup_req_t       lookup,
    output bp_pkg::update_req_t       update
);
    import bp_pkg::*;

    opcode_e     op;           // typed view of the opcode
    logic [31:0] hashed_pc;    // pc passed on only for branches

    assign op = opcode_e'(opcode);

    // only conditional branches use the direction table
    always_comb begin
        case (op)
            op_branch: begin
                is_branch = 1'b1;
            end
            default: begin
                is_branch = 1'b0;  // jal/jalr included, always taken
            end
        endcase
    end

    assign hashed_pc = is_branch ? pc : 32'd0;

    // lookup address
    // bank from the word offset within a 16-byte group
    always_comb begin
        lookup.valid      = is_branch;
        lookup.addr.bank  = pc[3:2];
        lookup.addr.index = pc[9:4];   // upper bits alias
        lookup.pc         = hashed_pc;
    end

    // update address built the same way from the resolving pc
    always_comb begin
        update.valid      = resolve_valid;
        update.addr.bank  = resolve_pc[3:2];
        update.addr.index = resolve_pc[9:4];
        update.taken      = resolve_taken;  // actual outcome
    end

endmodule

`default_nettype wire

/* counter_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module counter_bank #(
    parameter int BANK_ID = 0   // matches addr.bank
) (
    input  wire  logic                clk,
    input  wire  logic                rst_n,
    input  wire  bp_pkg::lookup_req_t lookup,
    input  wire  bp_pkg::update_req_t update,
    output bp_pkg::bank_resp_t        resp
);
    import bp_pkg::*;

    counter_e table_q [BANK_DEPTH];  // the counters of this bank
    logic     lk_hit;                // lookup targets this bank
    logic     up_hit;                // update targets this bank
    counter_e cur_state;             // counter at the update index
    counter_e nxt_state;

    assign lk_hit = lookup.valid && (lookup.addr.bank == BANK_W'(BANK_ID));
    assign up_hit = update.valid && (update.addr.bank == BANK_W'(BANK_ID));

    assign cur_state = table_q[update.addr.index];

    // saturating up on taken, down on not taken
    always_comb begin
        case (cur_state)
            strong_not: begin
                nxt_state = update.taken ? weak_not : strong_not;
            end
            weak_not: begin
                nxt_state = update.taken ? weak_taken : strong_not;
            end
            weak_taken: begin
                nxt_state = update.taken ? strong_taken : weak_not;
            end
            default: begin  // strong_taken
                nxt_state = update.taken ? strong_taken : weak_taken;
            end
        endcase
    end

    // counter write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                table_q[i] <= weak_not;
            end
        end else if (up_hit) begin
            table_q[update.addr.index] <= nxt_state;
        end
    end

    // registered read port
    // reads the array before this edge's write lands
    always_ff @(posedge clk) begin
        if (lk_hit) begin
            resp.read_state <= table_q[lookup.addr.index];
        end
        if (up_hit) begin
            resp.old_state <= cur_state;  // pre-update value for mispredict
        end
    end

endmodule

`default_nettype wire

/* predict_select.sv */
`timescale 1ns/1ps
`default_nettype none

module predict_select (
    input  wire  logic                                    clk,
    input  wire  logic                                    rst_n,
    input  wire  bp_pkg::lookup_req_t                     lookup,
    input  wire  bp_pkg::update_req_t                     update,
    input  wire  bp_pkg::bank_resp_t [bp_pkg::N_BANKS-1:0] resp,
    output logic                                          predict_valid,
    output logic                                          predict_taken,
    output logic [31:0]                                   predict_pc,
    output logic                                          mispredict,
    output logic [15:0]                                   mispredict_count
);
    import bp_pkg::*;

    // lookup side, aligned with the bank read
    logic              lk_valid_q;
    logic [BANK_W-1:0] lk_bank_q;
    logic [31:0]       lk_pc_q;

    // update side, aligned with the bank old state
    logic              up_valid_q;
    logic [BANK_W-1:0] up_bank_q;
    logic              up_taken_q;

    bank_resp_t lk_resp;   // response of the looked-up bank
    bank_resp_t up_resp;   // response of the updated bank
    logic       mis_hit;   // outcome disagrees with old counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_valid_q <= 1'b0;
            up_valid_q <= 1'b0;
        end else begin
            lk_valid_q <= lookup.valid;
            up_valid_q <= update.valid;
        end
    end

    // bank selects and payload, qualified by the valids above
    always_ff @(posedge clk) begin
        lk_bank_q  <= lookup.addr.bank;
        lk_pc_q    <= lookup.pc;
        up_bank_q  <= update.addr.bank;
        up_taken_q <= update.taken;
    end

    assign lk_resp = resp[lk_bank_q];
    assign up_resp = resp[up_bank_q];

    assign mis_hit = up_valid_q && (up_taken_q != up_resp.old_state[1]);

    // output stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            predict_valid    <= 1'b0;
            predict_taken    <= 1'b0;
            predict_pc       <= 32'd0;
            mispredict       <= 1'b0;
            mispredict_count <= 16'd0;
        end else begin
            predict_valid <= lk_valid_q;
            predict_taken <= lk_valid_q && lk_resp.read_state[1];  // msb is direction
            predict_pc    <= lk_pc_q;    // already zero for non-branches
            mispredict    <= mis_hit;     // one-cycle pulse
            if (mis_hit && (mispredict_count != 16'hffff)) begin
                mispredict_count <= mispredict_count + 16'd1;  // saturates
            end
        end
    end

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire  logic        clk,
    input  wire  logic        rst_n,
    // fetch stage
    input  wire  logic [6:0]  opcode,
    input  wire  logic [31:0] pc,
    // mem stage resolve
    input  wire  logic        resolve_valid,
    input  wire  logic [31:0] resolve_pc,
    input  wire  logic        resolve_taken,
    // prediction
    output logic              is_branch,        // combinational decode
    output logic              predict_valid,
    output logic              predict_taken,
    output logic [31:0]       predict_pc,
    output logic              mispredict,
    output logic [15:0]       mispredict_count
);
    import bp_pkg::*;

    lookup_req_t                 lookup_req;   // broadcast to every bank
    update_req_t                 update_req;   // broadcast to every bank
    bank_resp_t [N_BANKS-1:0]    bank_resp;    // one slot per bank

    branch_detect u_detect (
        .opcode        (opcode),
        .pc            (pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .is_branch     (is_branch),
        .lookup        (lookup_req),
        .update        (update_req)
    );

    // history table, one bank per pc[3:2] value
    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        counter_bank #(
            .BANK_ID (b)
        ) u_bank (
            .clk    (clk),
            .rst_n  (rst_n),
            .lookup (lookup_req),
            .update (update_req),
            .resp   (bank_resp[b])
        );
    end

    predict_select u_select (
        .clk              (clk),
        .rst_n            (rst_n),
        .lookup           (lookup_req),
        .update           (update_req),
        .resp             (bank_resp),
        .predict_valid    (predict_valid),
        .predict_taken    (predict_taken),
        .predict_pc       (predict_pc),
        .mispredict       (mispredict),
        .mispredict_count (mispredict_count)
    );

endmodule

`default_nettype wire

/* tb_branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;
    import bp_pkg::*;

    // one line of the directed case file
    typedef struct packed {
        logic [6:0]  opcode;
        logic [31:0] pc;
        logic        rv;
        logic [31:0] rpc;
        logic        rt;
        logic        isb;   // expected is_branch, same cycle
        logic        pv;    // expected predict_valid
        logic        pt;    // expected predict_taken
        logic        mis;   // expected mispredict
    } case_t;

    // outputs expected two edges after the inputs are driven
    typedef struct packed {
        logic        pv;
        logic        pt;
        logic [31:0] ppc;
        logic        mis;
        logic [15:0] cnt;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic [6:0]  opcode;
    logic [31:0] pc;
    logic        resolve_valid;
    logic [31:0] resolve_pc;
    logic        resolve_taken;
    logic        is_branch;
    logic        predict_valid;
    logic        predict_taken;
    logic [31:0] predict_pc;
    logic        mispredict;
    logic [15:0] mispredict_count;

    case_t       case_q [$];     // directed lines from the file
    expect_t     exp_q [$];      // results still in flight
    logic [1:0]  model_tbl [256];  // {bank, index} addressed reference table
    logic [15:0] exp_count;
    int          err_count = 0;
    int          cycle_cnt = 0;
    int          max_cycles = 0;  // 0 until the case file is loaded

    branch_predictor UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .opcode           (opcode),
        .pc               (pc),
        .resolve_valid    (resolve_valid),
        .resolve_pc       (resolve_pc),
        .resolve_taken    (resolve_taken),
        .is_branch        (is_branch),
        .predict_valid    (predict_valid),
        .predict_taken    (predict_taken),
        .predict_pc       (predict_pc),
        .mispredict       (mispredict),
        .mispredict_count (mispredict_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (max_cycles > 0 && cycle_cnt >= max_cycles) begin
            $display("timeout: the run went past %0d clock cycles", max_cycles);
            $display("Test failures found");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            err_count++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // taken counts up, not taken counts down, both saturate
    function automatic logic [1:0] saturate_step(input logic [1:0] s, input logic taken);
        if (taken) begin
            return (s == 2'd3) ? s : s + 2'd1;
        end
        return (s == 2'd0) ? s : s - 2'd1;
    endfunction

    function automatic logic [7:0] table_slot(input logic [31:0] addr);
        return {addr[3:2], addr[9:4]};   // bank then index
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        logic [8*200-1:0] line_buf;
        logic [31:0] f [9];
        case_t       c;
        fd = $fopen("branch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open branch_cases.txt for reading");
            $display("Test failures found");
            $fatal(1, "missing case file");
        end
        while ($fgets(line_buf, fd) != 0) begin
            n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n == 9) begin  // comment and blank lines give fewer fields
                c = {f[0][6:0], f[1], f[2][0], f[3], f[4][0],
                     f[5][0], f[6][0], f[7][0], f[8][0]};
                case_q.push_back(c);
            end
        end
        $fclose(fd);
        if (case_q.size() == 0) begin
            $display("branch_cases.txt held no usable case lines");
            $display("Test failures found");
            $fatal(1, "empty case file");
        end
    endtask

    // drive one cycle, advance the model, check what is due now
    task automatic run_cycle(input logic [6:0] op, input logic [31:0] lpc, input logic rv,
                             input logic [31:0] rpc, input logic rt,
                             input logic from_file, input case_t fc);
        expect_t e;
        expect_t due;
        logic    isb;
        logic    mis_m;
        logic [7:0] lk;
        logic [7:0] up;
        @(posedge clk);
        opcode        <= op;
        pc            <= lpc;
        resolve_valid <= rv;
        resolve_pc    <= rpc;
        resolve_taken <= rt;
        isb   = (op == op_branch);
        lk    = table_slot(lpc);
        up    = table_slot(rpc);
        e.pv  = isb;
        e.pt  = isb && model_tbl[lk][1];   // read before this cycle's write
        e.ppc = isb ? lpc : 32'd0;
        mis_m = rv && (rt != model_tbl[up][1]);
        if (rv) begin
            model_tbl[up] = saturate_step(model_tbl[up], rt);
        end
        e.mis = mis_m;
        if (from_file) begin
            isb   = fc.isb;
            e.pv  = fc.pv;
            e.pt  = fc.pt;
            e.mis = fc.mis;
        end
        if (e.mis && exp_count != 16'hffff) begin
            exp_count = exp_count + 16'd1;
        end
        e.cnt = exp_count;
        exp_q.push_back(e);
        @(negedge clk);
        check("is_branch", is_branch, isb);   // combinational decode
        if (exp_q.size() > 2) begin
            due = exp_q.pop_front();
            check("predict_valid", predict_valid, due.pv);
            check("predict_taken", predict_taken, due.pt);
            check("predict_pc", predict_pc, due.ppc);
            check("mispredict", mispredict, due.mis);
            check("mispredict_count", mispredict_count, due.cnt);
        end
    endtask

    initial begin
        logic [6:0]  r_op;
        logic [31:0] r_pc;
        logic [31:0] r_rpc;
        logic        r_rv;
        logic        r_rt;
        rst_n         = 1'b0;
        opcode        = 7'd0;
        pc            = 32'd0;
        resolve_valid = 1'b0;
        resolve_pc    = 32'd0;
        resolve_taken = 1'b0;
        exp_count     = 16'd0;
        void'($urandom(22215));
        for (int i = 0; i < 256; i++) begin
            model_tbl[i] = 2'd1;   // weak not-taken
        end
        load_cases();
        max_cycles = 8 + case_q.size() + 400 + 50;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("predict_valid", predict_valid, 0);
        check("predict_taken", predict_taken, 0);
        check("mispredict", mispredict, 0);
        check("mispredict_count", mispredict_count, 0);

        // directed lines
        foreach (case_q[i]) begin
            run_cycle(case_q[i].opcode, case_q[i].pc, case_q[i].rv,
                      case_q[i].rpc, case_q[i].rt, 1'b1, case_q[i]);
        end

        // random traffic over a small set of entries so they collide
        repeat (400) begin
            r_pc = {22'($urandom() % 32'h0040_0000), 6'($urandom() % 8),
                    2'($urandom() % 4), 2'b00};
            if ($urandom() % 100 < 70) begin
                r_op = op_branch;
            end else begin
                case ($urandom() % 6)
                    0: r_op = op_jal;
                    1: r_op = op_jalr;
                    2: r_op = op_load;
                    3: r_op = op_store;
                    4: r_op = op_alu;
                    default: r_op = op_alui;
                endcase
            end
            r_rv = ($urandom() % 2) == 0;
            if ($urandom() % 8 == 0) begin
                r_rpc = r_pc;   // same-entry conflict
            end else begin
                r_rpc = {22'($urandom() % 32'h0040_0000), 6'($urandom() % 8),
                         2'($urandom() % 4), 2'b00};
            end
            r_rt = ($urandom() % 10) < 7;   // mostly taken
            run_cycle(r_op, r_pc, r_rv, r_rpc, r_rt, 1'b0, '0);
        end

        // drain the last two results
        repeat (2) begin
            run_cycle(op_alui, 32'd0, 1'b0, 32'd0, 1'b0, 1'b0, '0);
        end

        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
bp_pkg.sv
branch_detect.sv
counter_bank.sv
predict_select.sv
branch_predictor.sv
tb_branch_predictor.sv

/* branch_cases.txt */
# opcode pc rv resolve_pc rt | is_branch predict_valid predict_taken mispredict (all hex)
# expected columns belong to this line's lookup and resolve; counters start weak not-taken
# after reset every branch lookup predicts not-taken
63 00000104 0 00000000 0  1 1 0 0
63 00000ab8 0 00000000 0  1 1 0 0
# non-branch opcodes give no prediction and a zero pc
13 00000104 0 00000000 0  0 0 0 0
6f 00000200 0 00000000 0  0 0 0 0
67 00000204 0 00000000 0  0 0 0 0
33 00000ff0 0 00000000 0  0 0 0 0
# same-cycle lookup and update of 0x104 returns the old counter
63 00000104 1 00000104 1  1 1 0 1
63 00000104 0 00000000 0  1 1 1 0
# saturate up, then one not-taken keeps it predicting taken
63 00000104 1 00000104 1  1 1 1 0
63 00000104 1 00000104 1  1 1 1 0
63 00000104 1 00000104 0  1 1 1 1
63 00000104 0 00000000 0  1 1 1 0
# walk down to strong not-taken and hold there
13 00000000 1 00000104 0  0 0 0 1
63 00000104 0 00000000 0  1 1 0 0
13 00000000 1 00000104 0  0 0 0 0
13 00000000 1 00000104 0  0 0 0 0
13 00000000 1 00000104 1  0 0 0 1
63 00000104 0 00000000 0  1 1 0 0
# bank and index separation, upper pc bits alias
13 00000000 1 00000104 1  0 0 0 1
63 00000108 0 00000000 0  1 1 0 0
63 00000114 0 00000000 0  1 1 0 0
63 abcd0104 0 00000000 0  1 1 1 0
63 00000104 0 00000000 0  1 1 1 0
# train 0x114 through an aliasing resolve pc
13 00000000 1 fff00114 1  0 0 0 1
63 00000114 0 00000000 0  1 1 1 0
# back to back updates of 0x108, second sees the first
63 00000108 1 00000108 1  1 1 0 1
63 00000108 1 00000108 0  1 1 1 1
63 00000108 0 00000000 0  1 1 0 0
63 00000104 0 00000000 0  1 1 1 0
# lookup in bank 3 while bank 1 resolves
63 0000010c 1 00000104 0  1 1 0 1
63 00000104 1 00000104 0  1 1 0 0
13 00000104 0 00000000 0  0 0 0 0
# last entry of bank 3
63 00000ffc 1 00000ffc 1  1 1 0 1
63 00000ffc 0 00000000 0  1 1 1 0
03 00000ffc 0 00000000 0  0 0 0 0
# strong not-taken entry resolved not-taken, no mispredict
63 00000104 1 00000104 0  1 1 0 0
63 00000104 0 00000000 0  1 1 0 0
# jalr and store never train or look up
67 00000108 0 00000000 0  0 0 0 0
23 00000114 0 00000000 0  0 0 0 0
# resolve without a valid strobe leaves counters alone
63 00000114 0 00000114 0  1 1 1 0
63 00000114 0 00000000 0  1 1 1 0
